// File: pe_ctrl_top.f
+incdir+src
src/pe_ctrl_pkg.sv
src/pe_phase_ctrl.sv
src/tile_loop_counter.sv
src/buffer_pingpong_ctrl.sv
src/threshold_ram.sv
src/threshold_fetch.sv
src/pe_ctrl_top.sv
tb/tb_pe_ctrl_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the pe_ctrl_top testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_pe_ctrl_top \
    -f pe_ctrl_top.f -Mdir obj_dir -o sim_pe_ctrl_top
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_pe_ctrl_top > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test completed successfully" "$log"; then
    exit 0
fi
exit 1

// File: src/buffer_pingpong_ctrl.sv
`timescale 1ns/1ps

module buffer_pingpong_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  pe_ctrl_pkg::buf_pair_t buf_valid,
    input  logic                  tile_fin,
    input  logic                  ol_fin,
    input  logic                  swu_ic_fin,
    input  pe_ctrl_pkg::pe_phase_e phase,
    output pe_ctrl_pkg::buf_pair_t buf_ready
);
    import pe_ctrl_pkg::*;

    buf_sel_e sel;
    buf_sel_e sel_nxt;
    logic     swu_sel;
    logic     weg_sel;
    logic     in_cmp;
    logic     pair_vld;
    logic     swu_nxt;
    logic     weg_nxt;

    // state bits carry the selected buffers directly
    assign swu_sel = sel[2];
    assign weg_sel = sel[1];
    assign in_cmp  = sel[0];

    assign pair_vld = (swu_sel ? buf_valid.swu1 : buf_valid.swu0) &&
                      (weg_sel ? buf_valid.weg1 : buf_valid.weg0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel <= S0W0_IDLE;
        end else begin
            sel <= sel_nxt;
        end
    end

    //////////////////////////////////////////////////
    // next buffer pair
    //////////////////////////////////////////////////

    always_comb begin
        swu_nxt = swu_sel;
        weg_nxt = weg_sel;
        case (phase)
            // integer layer sweeps ol with a fixed weight set
            INT_CMP: begin
                swu_nxt = ~swu_sel;
                weg_nxt = ol_fin ? ~weg_sel : weg_sel;
            end
            BIN_CMP: begin
                swu_nxt = swu_ic_fin ? ~swu_sel : swu_sel;
                weg_nxt = ~weg_sel;
            end
            default: begin
                swu_nxt = 1'b0;
                weg_nxt = 1'b0;
            end
        endcase
    end

    always_comb begin
        sel_nxt = sel;
        if (!in_cmp) begin
            if (pair_vld) begin
                sel_nxt = buf_sel_e'({swu_sel, weg_sel, 1'b1});
            end
        end else if (tile_fin) begin
            sel_nxt = buf_sel_e'({swu_nxt, weg_nxt, 1'b0});
        end
    end

    assign buf_ready.swu0 = in_cmp && !swu_sel;
    assign buf_ready.swu1 = in_cmp && swu_sel;
    assign buf_ready.weg0 = in_cmp && !weg_sel;
    assign buf_ready.weg1 = in_cmp && weg_sel;

endmodule

// File: src/pe_ctrl_config.svh
`ifndef PE_CTRL_CONFIG_SVH
`define PE_CTRL_CONFIG_SVH

// network depth
`define PE_NUM_LYR      5

// output length per layer
`define PE_LYR0_OL      300
`define PE_LYR1_OL      150
`define PE_LYR2_OL      75
`define PE_LYR3_OL      37
`define PE_LYR4_OL      18

// input channels of the binary layers
`define PE_LYR1_IC      64
`define PE_LYR2_IC      64
`define PE_LYR3_IC      128
`define PE_LYR4_IC      128

// output channels per layer
`define PE_LYR0_OC      64
`define PE_LYR1_OC      64
`define PE_LYR2_OC      128
`define PE_LYR3_OC      128
`define PE_LYR4_OC      256

// tile steps
`define PE_OL_STEP      12
`define PE_IC_STEP      2
`define PE_OC_STEP      32
`define PE_SWU_IC_SPAN  16

// threshold ram layout, layer 0 starts at word 0
`define PE_THR_WORDS    8
`define PE_THR_BASE1    16
`define PE_THR_BASE2    32
`define PE_THR_BASE3    64
`define PE_THR_BASE4    96

`endif

// File: src/pe_ctrl_pkg.sv
package pe_ctrl_pkg;

    typedef logic [2:0]   lyr_cnt_t;
    typedef logic [8:0]   loop_cnt_t;
    typedef logic [4:0]   swu_ic_t;
    typedef logic [7:0]   thr_addr_t;
    typedef logic [31:0]  thr_word_t;
    typedef logic [255:0] threshold_t;

    typedef enum logic [1:0] {
        IDLE,
        INT_CMP,
        BIN_CMP,
        DONE
    } pe_phase_e;

    // bit 2 selects the switch buffer, bit 1 the weight buffer, bit 0 is compute
    typedef enum logic [2:0] {
        S0W0_IDLE,
        S0W0_CMP,
        S0W1_IDLE,
        S0W1_CMP,
        S1W0_IDLE,
        S1W0_CMP,
        S1W1_IDLE,
        S1W1_CMP
    } buf_sel_e;

    typedef struct packed {
        logic swu0;
        logic swu1;
        logic weg0;
        logic weg1;
    } buf_pair_t;

    typedef struct packed {
        swu_ic_t ic_cnt;
        logic    swu_ic_fin;
        logic    weg_ol_fin;
    } tile_status_t;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        thr_addr_t paddr;
        thr_word_t pwdata;
    } apb_req_t;

endpackage

// File: src/pe_ctrl_top.sv
`timescale 1ns/1ps

module pe_ctrl_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     ecg_start,
    input  logic [1:0]               swu_fin,
    input  pe_ctrl_pkg::buf_pair_t    buf_valid,
    input  pe_ctrl_pkg::apb_req_t     apb,
    output pe_ctrl_pkg::buf_pair_t    buf_ready,
    output pe_ctrl_pkg::tile_status_t tile_status,
    output pe_ctrl_pkg::pe_phase_e    phase,
    output logic                     thr_valid,
    output pe_ctrl_pkg::threshold_t   threshold
);
    import pe_ctrl_pkg::*;

    lyr_cnt_t  lyr;
    logic      tile_fin;
    logic      ol_fin;
    logic      layer_fin;
    logic      oc_incr;
    logic      rd_en;
    thr_addr_t rd_addr;
    thr_word_t rd_data;

    pe_phase_ctrl i_pe_phase_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .ecg_start (ecg_start),
        .layer_fin (layer_fin),
        .phase     (phase),
        .lyr       (lyr)
    );

    tile_loop_counter i_tile_loop_counter (
        .clk         (clk),
        .rst_n       (rst_n),
        .swu_fin     (swu_fin),
        .phase       (phase),
        .lyr         (lyr),
        .tile_fin    (tile_fin),
        .ol_fin      (ol_fin),
        .layer_fin   (layer_fin),
        .oc_incr     (oc_incr),
        .tile_status (tile_status)
    );

    buffer_pingpong_ctrl i_buffer_pingpong_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .buf_valid  (buf_valid),
        .tile_fin   (tile_fin),
        .ol_fin     (ol_fin),
        .swu_ic_fin (tile_status.swu_ic_fin),
        .phase      (phase),
        .buf_ready  (buf_ready)
    );

    //////////////////////////////////////////////////
    // threshold path
    //////////////////////////////////////////////////

    threshold_fetch i_threshold_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .ecg_start (ecg_start),
        .oc_incr   (oc_incr),
        .layer_fin (layer_fin),
        .lyr       (lyr),
        .rd_data   (rd_data),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .thr_valid (thr_valid),
        .threshold (threshold)
    );

    threshold_ram i_threshold_ram (
        .clk     (clk),
        .apb     (apb),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

// File: src/pe_phase_ctrl.sv
`timescale 1ns/1ps
`include "pe_ctrl_config.svh"

module pe_phase_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ecg_start,
    input  logic                  layer_fin,
    output pe_ctrl_pkg::pe_phase_e phase,
    output pe_ctrl_pkg::lyr_cnt_t  lyr
);
    import pe_ctrl_pkg::*;

    pe_phase_e phase_nxt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= IDLE;
        end else begin
            phase <= phase_nxt;
        end
    end

    always_comb begin
        phase_nxt = phase;
        case (phase)
            IDLE: begin
                if (ecg_start) begin
                    phase_nxt = INT_CMP;
                end
            end
            // only layer 0 is an integer layer
            INT_CMP: begin
                if (layer_fin) begin
                    phase_nxt = BIN_CMP;
                end
            end
            BIN_CMP: begin
                if (layer_fin && lyr == lyr_cnt_t'(`PE_NUM_LYR - 1)) begin
                    phase_nxt = DONE;
                end
            end
            default: begin
                phase_nxt = DONE;
            end
        endcase
    end

    // layer index
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lyr <= '0;
        end else if (layer_fin) begin
            lyr <= lyr + 1'b1;
        end
    end

endmodule

// File: src/threshold_fetch.sv
`timescale 1ns/1ps
`include "pe_ctrl_config.svh"

module threshold_fetch (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   ecg_start,
    input  logic                   oc_incr,
    input  logic                   layer_fin,
    input  pe_ctrl_pkg::lyr_cnt_t   lyr,
    input  pe_ctrl_pkg::thr_word_t  rd_data,
    output logic                   rd_en,
    output pe_ctrl_pkg::thr_addr_t  rd_addr,
    output logic                   thr_valid,
    output pe_ctrl_pkg::threshold_t threshold
);
    import pe_ctrl_pkg::*;

    localparam int CNT_W = $clog2(`PE_THR_WORDS);

    typedef logic [CNT_W-1:0] rd_cnt_t;
    typedef enum logic {
        FETCH_IDLE,
        FETCH_READ
    } fetch_state_e;

    localparam rd_cnt_t RD_LAST = rd_cnt_t'(`PE_THR_WORDS - 1);

    fetch_state_e                     state;
    thr_addr_t                        base;
    thr_addr_t                        base_nxt_lyr;
    rd_cnt_t                          rd_cnt;
    rd_cnt_t                          rd_cnt_d;
    logic                             rd_vld;
    logic                             blk_last;
    thr_word_t [`PE_THR_WORDS-1:0]    thr_sreg;

    //////////////////////////////////////////////////
    // block base address
    //////////////////////////////////////////////////

    always_comb begin
        case (lyr)
            3'd0:    base_nxt_lyr = thr_addr_t'(`PE_THR_BASE1);
            3'd1:    base_nxt_lyr = thr_addr_t'(`PE_THR_BASE2);
            3'd2:    base_nxt_lyr = thr_addr_t'(`PE_THR_BASE3);
            3'd3:    base_nxt_lyr = thr_addr_t'(`PE_THR_BASE4);
            default: base_nxt_lyr = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            base <= '0;
        end else if (layer_fin) begin
            base <= base_nxt_lyr;
        end else if (thr_valid) begin
            base <= base + thr_addr_t'(`PE_THR_WORDS);
        end
    end

    //////////////////////////////////////////////////
    // read sequencer
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= FETCH_IDLE;
            rd_cnt <= '0;
        end else if (state == FETCH_IDLE) begin
            rd_cnt <= '0;
            if (ecg_start || oc_incr) begin
                state <= FETCH_READ;
            end
        end else begin
            rd_cnt <= rd_cnt + 1'b1;
            if (rd_cnt == RD_LAST) begin
                state <= FETCH_IDLE;
            end
        end
    end

    assign rd_en   = (state == FETCH_READ);
    assign rd_addr = base + thr_addr_t'(rd_cnt);

    // ram data lines up with the delayed count
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_vld    <= 1'b0;
            rd_cnt_d  <= '0;
            blk_last  <= 1'b0;
            thr_valid <= 1'b0;
        end else begin
            rd_vld    <= rd_en;
            rd_cnt_d  <= rd_cnt;
            blk_last  <= rd_vld && (rd_cnt_d == RD_LAST);
            thr_valid <= blk_last;
        end
    end

    // newest word enters at the top, base word ends up at the bottom
    always_ff @(posedge clk) begin
        if (rd_vld) begin
            thr_sreg <= {rd_data, thr_sreg[`PE_THR_WORDS-1:1]};
        end
    end

    assign threshold = thr_sreg;

endmodule

// File: src/threshold_ram.sv
`timescale 1ns/1ps

module threshold_ram (
    input  logic                  clk,
    input  pe_ctrl_pkg::apb_req_t  apb,
    input  logic                  rd_en,
    input  pe_ctrl_pkg::thr_addr_t rd_addr,
    output pe_ctrl_pkg::thr_word_t rd_data
);
    import pe_ctrl_pkg::*;

    localparam int DEPTH = 2 ** $bits(thr_addr_t);

    thr_word_t mem [DEPTH];
    logic      apb_wr;

    // access phase of an apb write
    assign apb_wr = apb.psel && apb.penable && apb.pwrite;

    always_ff @(posedge clk) begin
        if (apb_wr) begin
            mem[apb.paddr] <= apb.pwdata;
        end
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: src/tile_loop_counter.sv
`timescale 1ns/1ps
`include "pe_ctrl_config.svh"

module tile_loop_counter (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [1:0]               swu_fin,
    input  pe_ctrl_pkg::pe_phase_e    phase,
    input  pe_ctrl_pkg::lyr_cnt_t     lyr,
    output logic                     tile_fin,
    output logic                     ol_fin,
    output logic                     layer_fin,
    output logic                     oc_incr,
    output pe_ctrl_pkg::tile_status_t tile_status
);
    import pe_ctrl_pkg::*;

    localparam swu_ic_t SWU_IC_LAST = swu_ic_t'((`PE_SWU_IC_SPAN - 1) * `PE_IC_STEP);

    loop_cnt_t ol_cnt;
    loop_cnt_t ic_cnt;
    loop_cnt_t oc_cnt;
    loop_cnt_t ol_lim;
    loop_cnt_t ic_lim;
    loop_cnt_t oc_lim;
    logic      ic_fin;
    logic      oc_fin;
    logic      oc_adv;
    logic      loop_act;

    assign tile_fin = |swu_fin;
    assign loop_act = (phase == INT_CMP) || (phase == BIN_CMP);

    //////////////////////////////////////////////////
    // per layer limits
    //////////////////////////////////////////////////

    always_comb begin
        case (lyr)
            3'd0: begin
                ol_lim = loop_cnt_t'(`PE_LYR0_OL - 1);
                ic_lim = '0;
                oc_lim = loop_cnt_t'(`PE_LYR0_OC - `PE_OC_STEP);
            end
            3'd1: begin
                ol_lim = loop_cnt_t'(`PE_LYR1_OL - `PE_OL_STEP);
                ic_lim = loop_cnt_t'(`PE_LYR1_IC - `PE_IC_STEP);
                oc_lim = loop_cnt_t'(`PE_LYR1_OC - `PE_OC_STEP);
            end
            3'd2: begin
                ol_lim = loop_cnt_t'(`PE_LYR2_OL - `PE_OL_STEP);
                ic_lim = loop_cnt_t'(`PE_LYR2_IC - `PE_IC_STEP);
                oc_lim = loop_cnt_t'(`PE_LYR2_OC - `PE_OC_STEP);
            end
            3'd3: begin
                ol_lim = loop_cnt_t'(`PE_LYR3_OL - `PE_OL_STEP);
                ic_lim = loop_cnt_t'(`PE_LYR3_IC - `PE_IC_STEP);
                oc_lim = loop_cnt_t'(`PE_LYR3_OC - `PE_OC_STEP);
            end
            default: begin
                ol_lim = loop_cnt_t'(`PE_LYR4_OL - `PE_OL_STEP);
                ic_lim = loop_cnt_t'(`PE_LYR4_IC - `PE_IC_STEP);
                oc_lim = loop_cnt_t'(`PE_LYR4_OC - `PE_OC_STEP);
            end
        endcase
    end

    //////////////////////////////////////////////////
    // loop counters
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ol_cnt <= '0;
            ic_cnt <= '0;
        end else if (tile_fin) begin
            case (phase)
                INT_CMP: begin
                    ol_cnt <= ol_fin ? '0 : ol_cnt + 1'b1;
                    ic_cnt <= '0;
                end
                BIN_CMP: begin
                    // ol only moves once all input channels are done
                    if (ic_fin) begin
                        ol_cnt <= ol_fin ? '0 : ol_cnt + loop_cnt_t'(`PE_OL_STEP);
                    end
                    ic_cnt <= ic_fin ? '0 : ic_cnt + loop_cnt_t'(`PE_IC_STEP);
                end
                default: begin
                    ol_cnt <= '0;
                    ic_cnt <= '0;
                end
            endcase
        end
    end

    assign oc_adv = tile_fin && ((phase == INT_CMP && ol_fin) ||
                                 (phase == BIN_CMP && ol_fin && ic_fin));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            oc_cnt <= '0;
        end else if (oc_adv) begin
            oc_cnt <= oc_fin ? '0 : oc_cnt + loop_cnt_t'(`PE_OC_STEP);
        end
    end

    // finish flags lag the counts by a cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ol_fin  <= 1'b0;
            ic_fin  <= 1'b0;
            oc_fin  <= 1'b0;
            oc_incr <= 1'b0;
        end else begin
            ol_fin  <= loop_act && (ol_cnt >= ol_lim);
            ic_fin  <= loop_act && (ic_cnt >= ic_lim);
            oc_fin  <= loop_act && (oc_cnt >= oc_lim);
            oc_incr <= oc_adv;
        end
    end

    always_comb begin
        case (phase)
            INT_CMP: layer_fin = tile_fin && ol_fin && oc_fin;
            BIN_CMP: layer_fin = tile_fin && ol_fin && ic_fin && oc_fin;
            default: layer_fin = 1'b0;
        endcase
    end

    // status toward the switch unit and weight bank
    assign tile_status.ic_cnt     = ic_cnt[4:0];
    assign tile_status.swu_ic_fin = (ic_cnt[4:0] >= SWU_IC_LAST);
    assign tile_status.weg_ol_fin = (phase == INT_CMP) && tile_fin && ol_fin;

endmodule

// File: tb/pe_ctrl_stimulus.txt
// columns: fin delay, tiles in the layer, threshold blocks in the layer
// values in hex, one line per layer from layer 0 to layer 4
// integer layer
3 258 2
// binary layers
2 340 2
1 380 4
2 400 4
4 400 8

// File: tb/tb_pe_ctrl_top.sv
`timescale 1ns/1ps
`include "pe_ctrl_config.svh"

module tb_pe_ctrl_top;
    import pe_ctrl_pkg::*;

    // ecg_start to thr_valid, a cycle to start the fetch and ten more to finish it
    localparam int FETCH_LAT = 11;
    localparam int WITHHOLD_CYC = 20;
    localparam buf_pair_t NO_READY = '0;

    logic         clk;
    logic         rst_n;
    logic         ecg_start;
    logic [1:0]   swu_fin;
    buf_pair_t    buf_valid;
    apb_req_t     apb;
    buf_pair_t    buf_ready;
    tile_status_t tile_status;
    pe_phase_e    phase;
    logic         thr_valid;
    threshold_t   threshold;

    // three entries per layer: fin delay, tile count, block count
    logic [31:0]  stim [3*`PE_NUM_LYR];
    thr_word_t    mirror [256];
    integer       seed;
    int           cyc;
    int           cycle_limit;
    int           value_errs;
    int           other_errs;
    int           cur_lyr;
    int           blk_cnt [`PE_NUM_LYR+1];
    bit           thr_valid_d;
    thr_addr_t    exp_base_q [$];
    int           exp_cyc_q [$];

    // reference loop state
    int           m_ol;
    int           m_ic;
    int           m_oc;
    int           m_tile;
    bit           m_swu;
    bit           m_weg;
    thr_addr_t    m_base;

    pe_ctrl_top i_pe_ctrl_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .ecg_start   (ecg_start),
        .swu_fin     (swu_fin),
        .buf_valid   (buf_valid),
        .apb         (apb),
        .buf_ready   (buf_ready),
        .tile_status (tile_status),
        .phase       (phase),
        .thr_valid   (thr_valid),
        .threshold   (threshold)
    );

    initial begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (cyc > cycle_limit) begin
            $display("timeout, the run did not end within %0d cycles", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////

    task automatic check_buf(input string name, input buf_pair_t got, input buf_pair_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("[FAIL] %s got %h exp %h at cycle %0d", name, got, exp, cyc);
        end
    endtask

    task automatic check_status(input tile_status_t got, input tile_status_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("[FAIL] tile_status got %h exp %h at cycle %0d", got, exp, cyc);
        end
    endtask

    task automatic check_phase(input pe_phase_e got, input pe_phase_e exp);
        if (got !== exp) begin
            value_errs++;
            $display("[FAIL] phase got %h exp %h at cycle %0d", got, exp, cyc);
        end
    endtask

    task automatic check_threshold(input threshold_t got, input threshold_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("[FAIL] threshold got %h exp %h at cycle %0d", got, exp, cyc);
        end
    endtask

    task automatic report_error(input string msg);
        other_errs++;
        $display("error at cycle %0d: %s", cyc, msg);
    endtask

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    function automatic buf_pair_t sel_pair(input bit s, input bit w);
        buf_pair_t p;
        p.swu0 = !s;
        p.swu1 = s;
        p.weg0 = !w;
        p.weg1 = w;
        return p;
    endfunction

    function automatic int ol_limit(input int l);
        case (l)
            0:       return `PE_LYR0_OL - 1;
            1:       return `PE_LYR1_OL - `PE_OL_STEP;
            2:       return `PE_LYR2_OL - `PE_OL_STEP;
            3:       return `PE_LYR3_OL - `PE_OL_STEP;
            default: return `PE_LYR4_OL - `PE_OL_STEP;
        endcase
    endfunction

    function automatic int ic_limit(input int l);
        case (l)
            0:       return 0;
            1:       return `PE_LYR1_IC - `PE_IC_STEP;
            2:       return `PE_LYR2_IC - `PE_IC_STEP;
            3:       return `PE_LYR3_IC - `PE_IC_STEP;
            default: return `PE_LYR4_IC - `PE_IC_STEP;
        endcase
    endfunction

    function automatic int oc_limit(input int l);
        case (l)
            0:       return `PE_LYR0_OC - `PE_OC_STEP;
            1:       return `PE_LYR1_OC - `PE_OC_STEP;
            2:       return `PE_LYR2_OC - `PE_OC_STEP;
            3:       return `PE_LYR3_OC - `PE_OC_STEP;
            default: return `PE_LYR4_OC - `PE_OC_STEP;
        endcase
    endfunction

    // past the last layer the base falls back to the layer 0 block
    function automatic thr_addr_t layer_base(input int l);
        case (l)
            1:       return thr_addr_t'(`PE_THR_BASE1);
            2:       return thr_addr_t'(`PE_THR_BASE2);
            3:       return thr_addr_t'(`PE_THR_BASE3);
            4:       return thr_addr_t'(`PE_THR_BASE4);
            default: return '0;
        endcase
    endfunction

    function automatic threshold_t expected_block(input thr_addr_t base);
        threshold_t blk;
        for (int i = 0; i < `PE_THR_WORDS; i++) begin
            blk[i*32 +: 32] = mirror[(int'(base) + i) % 256];
        end
        return blk;
    endfunction

    task automatic apb_write(input thr_addr_t addr, input thr_word_t data);
        @(negedge clk);
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite  = 1'b1;
        apb.paddr   = addr;
        apb.pwdata  = data;
        @(negedge clk);
        apb.penable = 1'b1;
    endtask

    //////////////////////////////////////////////////
    // tile responder
    //////////////////////////////////////////////////

    task automatic run_tile(input int l, input int d, input bit withhold, output bit layer_end);
        buf_pair_t    sel;
        tile_status_t exp_st;
        pe_phase_e    exp_ph;
        bit           ol_last;
        bit           ic_last;
        bit           oc_last;
        bit           ic_wrap;
        bit           oc_step;
        sel       = sel_pair(m_swu, m_weg);
        exp_ph    = (l == 0) ? INT_CMP : BIN_CMP;
        ol_last   = (m_ol >= ol_limit(l));
        ic_last   = (m_ic >= ic_limit(l));
        oc_last   = (m_oc >= oc_limit(l));
        ic_wrap   = ((m_ic % 32) >= 30);
        layer_end = ol_last && ic_last && oc_last;

        // weight buffer held back, ready must not rise
        if (withhold) begin
            buf_valid      = sel;
            buf_valid.weg0 = 1'b0;
            buf_valid.weg1 = 1'b0;
            repeat (WITHHOLD_CYC) begin
                @(negedge clk);
                check_buf("buf_ready", buf_ready, NO_READY);
            end
        end
        buf_valid = sel;
        @(negedge clk);
        buf_valid = '0;
        check_buf("buf_ready", buf_ready, sel);
        check_phase(phase, exp_ph);

        for (int i = 1; i <= d; i++) begin
            @(negedge clk);
            check_buf("buf_ready", buf_ready, sel);
        end
        swu_fin = (m_tile % 2 == 0) ? 2'b01 : 2'b10;
        #1;
        exp_st.ic_cnt     = swu_ic_t'(m_ic % 32);
        exp_st.swu_ic_fin = ic_wrap;
        exp_st.weg_ol_fin = (l == 0) && ol_last;
        check_status(tile_status, exp_st);

        if (l == 0) begin
            oc_step = ol_last;
            m_ol    = ol_last ? 0 : m_ol + 1;
            m_swu   = !m_swu;
            m_weg   = ol_last ? !m_weg : m_weg;
        end else begin
            oc_step = ol_last && ic_last;
            if (ic_last) begin
                m_ol = ol_last ? 0 : m_ol + `PE_OL_STEP;
            end
            m_ic  = ic_last ? 0 : m_ic + `PE_IC_STEP;
            m_weg = !m_weg;
            m_swu = ic_wrap ? !m_swu : m_swu;
        end
        // every oc step fetches a new block
        if (oc_step) begin
            m_oc = oc_last ? 0 : m_oc + `PE_OC_STEP;
            if (layer_end) begin
                m_base = layer_base(l + 1);
            end
            exp_base_q.push_back(m_base);
            // oc_incr trails the tile finish by one cycle
            exp_cyc_q.push_back(cyc + FETCH_LAT + 1);
            m_base = m_base + thr_addr_t'(`PE_THR_WORDS);
        end
        m_tile++;

        @(negedge clk);
        swu_fin = 2'b00;
        check_buf("buf_ready", buf_ready, NO_READY);
        if (layer_end) begin
            check_phase(phase, (l == `PE_NUM_LYR - 1) ? DONE : BIN_CMP);
        end
    endtask

    //////////////////////////////////////////////////
    // threshold monitor
    //////////////////////////////////////////////////

    always @(negedge clk) begin : thr_monitor
        thr_addr_t base;
        int        due;
        if (rst_n) begin
            if (thr_valid && thr_valid_d) begin
                report_error("thr_valid stayed high for more than one cycle");
            end else if (thr_valid) begin
                if (exp_base_q.size() == 0) begin
                    report_error("threshold block arrived with no fetch outstanding");
                end else begin
                    base = exp_base_q.pop_front();
                    due  = exp_cyc_q.pop_front();
                    check_threshold(threshold, expected_block(base));
                    if (cyc != due) begin
                        report_error($sformatf("block came at cycle %0d, expected at %0d",
                                               cyc, due));
                    end
                    blk_cnt[cur_lyr]++;
                end
            end
            thr_valid_d = thr_valid;
        end
    end

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        bit layer_end;
        int tiles;
        rst_n     = 1'b0;
        ecg_start = 1'b0;
        swu_fin   = 2'b00;
        buf_valid = '0;
        apb       = '0;
        seed      = 32'h7c5b;
        m_base    = layer_base(0);

        $readmemh("tb/pe_ctrl_stimulus.txt", stim);
        cycle_limit = 5000;
        for (int l = 0; l < `PE_NUM_LYR; l++) begin
            cycle_limit += int'(stim[3*l+1]) * (int'(stim[3*l]) + 4);
        end
        for (int a = 0; a < 256; a++) begin
            mirror[a] = $random(seed);
        end

        repeat (16) @(negedge clk);
        check_buf("buf_ready", buf_ready, NO_READY);
        check_phase(phase, IDLE);
        if (thr_valid !== 1'b0) begin
            report_error("thr_valid is not low in reset");
        end
        rst_n = 1'b1;

        // load the threshold ram
        for (int a = 0; a < 256; a++) begin
            apb_write(thr_addr_t'(a), mirror[a]);
        end
        @(negedge clk);
        apb = '0;

        repeat (5) begin
            @(negedge clk);
            check_phase(phase, IDLE);
            check_buf("buf_ready", buf_ready, NO_READY);
            if (thr_valid !== 1'b0) begin
                report_error("thr_valid rose before start");
            end
        end

        ecg_start = 1'b1;
        exp_base_q.push_back(m_base);
        exp_cyc_q.push_back(cyc + FETCH_LAT);
        m_base = m_base + thr_addr_t'(`PE_THR_WORDS);
        @(negedge clk);
        ecg_start = 1'b0;
        check_phase(phase, INT_CMP);

        for (int l = 0; l < `PE_NUM_LYR; l++) begin
            tiles     = 0;
            layer_end = 1'b0;
            while (!layer_end) begin
                run_tile(l, int'(stim[3*l]), tiles == 3, layer_end);
                tiles++;
            end
            cur_lyr = l + 1;
            if (tiles != int'(stim[3*l+1])) begin
                report_error($sformatf("layer %0d took %0d tiles, file expects %0d",
                                       l, tiles, stim[3*l+1]));
            end
        end

        // nothing moves once the network is done
        repeat (100) begin
            @(negedge clk);
            check_phase(phase, DONE);
            check_buf("buf_ready", buf_ready, NO_READY);
        end

        if (exp_base_q.size() != 0) begin
            report_error($sformatf("%0d threshold blocks never arrived", exp_base_q.size()));
        end
        for (int l = 0; l < `PE_NUM_LYR; l++) begin
            if (blk_cnt[l] != int'(stim[3*l+2])) begin
                report_error($sformatf("layer %0d got %0d threshold blocks, file expects %0d",
                                       l, blk_cnt[l], stim[3*l+2]));
            end
        end

        $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
